//--- Bender.yml
package:
  name: mmu_xlat
  description: "Address translation unit with a CSR block and two translation ports"

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mmuCsrPkg.sv
      - source/mmuXlatPkg.sv
      - source/mmuCsrFile.sv
      - source/addressTranslator.sv
      - source/memoryMappingUnit.sv
  - target: test
    include_dirs:
      - source
      - tb
    files:
      - tb/tbMemoryMappingUnit.sv

//--- source/addressTranslator.sv
`timescale 1ns/10ps
`include "mmu_defs.svh"

module addressTranslator
    import mmuCsrPkg::*;
    import mmuXlatPkg::*;
#(
    parameter type tagType = logic
)
(
    input  logic                     clk,
    input  logic                     rst,

    input  crmd_t                    crmd,
    input  dmw_t                     dmw0,
    input  dmw_t                     dmw1,

    input  logic                     reqValid,
    input  logic [`MMU_VA_WIDTH-1:0] reqVaddr,
    input  opKind_t                  reqOp,
    input  tagType                   reqTag,
    input  logic                     stall,
    input  logic                     flush,

    output logic                     rspValid,
    output logic [`MMU_PA_WIDTH-1:0] rspPaddr,
    output memType_t                 rspMemType,
    output logic                     rspExcValid,
    output excCode_t                 rspExcCode,
    output excSub_t                  rspExcSub,
    output tagType                   rspTag
);

    localparam int SEG_WIDTH = DMW_VSEG_HI - DMW_VSEG_LO + 1;

    plv_t                     curPlv;
    logic                     directMode;
    logic [SEG_WIDTH-1:0]     vseg;
    logic                     dmw0Hit;
    logic                     dmw1Hit;
    logic [`MMU_PA_WIDTH-1:0] nextPaddr;
    memType_t                 nextMemType;
    logic                     nextExc;
    excCode_t                 nextExcCode;
    excSub_t                  nextExcSub;

    // window enabled for this plv and segment matches.
    function automatic logic windowHit(dmw_t dmw, plv_t plv, logic [SEG_WIDTH-1:0] seg);
        logic plvOk;
        plvOk = (dmw[DMW_PLV0] && plv == PLV_KERNEL) || (dmw[DMW_PLV3] && plv == PLV_USER);
        return plvOk && (dmw[DMW_VSEG_HI:DMW_VSEG_LO] == seg);
    endfunction

    // ****************************************
    // translation decision
    // ****************************************

    assign curPlv     = crmd[CRMD_PLV_HI:CRMD_PLV_LO];
    assign directMode = ({crmd[CRMD_PG], crmd[CRMD_DA]} == MODE_DIRECT);
    assign vseg       = reqVaddr[`MMU_VA_WIDTH-1 -: SEG_WIDTH];
    assign dmw0Hit    = windowHit(dmw0, curPlv, vseg);
    assign dmw1Hit    = windowHit(dmw1, curPlv, vseg);

    always_comb
    begin
        nextPaddr   = '0;
        nextMemType = '0;
        nextExc     = 1'b0;
        nextExcCode = NO_EXC;
        nextExcSub  = NONE;
        if (directMode)
        begin
            nextPaddr   = reqVaddr;
            nextMemType = (reqOp == FETCH) ? crmd[CRMD_DATF_HI:CRMD_DATF_LO]
                                           : crmd[CRMD_DATM_HI:CRMD_DATM_LO];
        end
        else if (dmw0Hit) // dmw0 has priority.
        begin
            nextPaddr   = {dmw0[DMW_PSEG_HI:DMW_PSEG_LO], reqVaddr[`MMU_VA_WIDTH-SEG_WIDTH-1:0]};
            nextMemType = dmw0[DMW_MAT_HI:DMW_MAT_LO];
        end
        else if (dmw1Hit)
        begin
            nextPaddr   = {dmw1[DMW_PSEG_HI:DMW_PSEG_LO], reqVaddr[`MMU_VA_WIDTH-SEG_WIDTH-1:0]};
            nextMemType = dmw1[DMW_MAT_HI:DMW_MAT_LO];
        end
        else if (curPlv != PLV_KERNEL && reqVaddr[`MMU_VA_WIDTH-1])
        begin
            nextExc     = 1'b1; // user touching upper half.
            nextExcCode = ADE;
            nextExcSub  = (reqOp == FETCH) ? ADEF : ADEM;
        end
        else
        begin
            nextExc     = 1'b1; // no tlb behind this, always refill.
            nextExcCode = TLBR;
        end
    end

    // ****************************************
    // output register
    // ****************************************

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            rspValid    <= 1'b0;
            rspExcValid <= 1'b0;
        end
        else if (!stall)
        begin
            rspValid    <= reqValid;
            rspExcValid <= reqValid && nextExc;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            rspPaddr   <= nextPaddr;
            rspMemType <= nextMemType;
            rspExcCode <= nextExcCode;
            rspExcSub  <= nextExcSub;
            rspTag     <= reqTag; // passed through untouched.
        end
    end

    // exception is only reported on a live response.
    excNeedsValid: assert property (@(posedge clk) disable iff (rst)
        rspExcValid |-> rspValid);

    // faulting access must not leak an address.
    excZeroPaddr: assert property (@(posedge clk) disable iff (rst)
        rspExcValid |-> (rspPaddr == '0));

endmodule

//--- source/memoryMappingUnit.sv
`timescale 1ns/10ps
`include "mmu_defs.svh"

module memoryMappingUnit
    import mmuCsrPkg::*;
    import mmuXlatPkg::*;
(
    input  logic                         clk,
    input  logic                         rst,

    // ****************************************
    // wishbone csr slave
    // ****************************************
    input  logic                         wbCyc,
    input  logic                         wbStb,
    input  logic                         wbWe,
    input  logic [`MMU_WB_ADR_WIDTH-1:0] wbAdr,
    input  logic [`MMU_WB_DAT_WIDTH-1:0] wbDatW,
    output logic [`MMU_WB_DAT_WIDTH-1:0] wbDatR,
    output logic                         wbAck,

    // ****************************************
    // port 0, instruction fetch
    // ****************************************
    input  logic                         fetchReqValid,
    input  logic [`MMU_VA_WIDTH-1:0]     fetchVaddr,
    input  fetchTag_t                    fetchTag,
    input  logic                         fetchStall,
    input  logic                         fetchFlush,
    output logic                         fetchRspValid,
    output logic [`MMU_PA_WIDTH-1:0]     fetchPaddr,
    output memType_t                     fetchMemType,
    output logic                         fetchExcValid,
    output excCode_t                     fetchExcCode,
    output excSub_t                      fetchExcSub,
    output fetchTag_t                    fetchRspTag,

    // ****************************************
    // port 1, load and store
    // ****************************************
    input  logic                         dataReqValid,
    input  logic [`MMU_VA_WIDTH-1:0]     dataVaddr,
    input  opKind_t                      dataOp,
    input  dataTag_t                     dataTag,
    input  logic                         dataStall,
    input  logic                         dataFlush,
    output logic                         dataRspValid,
    output logic [`MMU_PA_WIDTH-1:0]     dataPaddr,
    output memType_t                     dataMemType,
    output logic                         dataExcValid,
    output excCode_t                     dataExcCode,
    output excSub_t                      dataExcSub,
    output dataTag_t                     dataRspTag
);

    crmd_t crmd;
    dmw_t  dmw0;
    dmw_t  dmw1;

    mmuCsrFile csrFile
    (
        .clk    (clk),
        .rst    (rst),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .crmd   (crmd),
        .dmw0   (dmw0),
        .dmw1   (dmw1)
    );

    addressTranslator #(.tagType(fetchTag_t)) fetchXlat
    (
        .clk         (clk),
        .rst         (rst),
        .crmd        (crmd),
        .dmw0        (dmw0),
        .dmw1        (dmw1),
        .reqValid    (fetchReqValid),
        .reqVaddr    (fetchVaddr),
        .reqOp       (FETCH), // port 0 only fetches.
        .reqTag      (fetchTag),
        .stall       (fetchStall),
        .flush       (fetchFlush),
        .rspValid    (fetchRspValid),
        .rspPaddr    (fetchPaddr),
        .rspMemType  (fetchMemType),
        .rspExcValid (fetchExcValid),
        .rspExcCode  (fetchExcCode),
        .rspExcSub   (fetchExcSub),
        .rspTag      (fetchRspTag)
    );

    addressTranslator #(.tagType(dataTag_t)) dataXlat
    (
        .clk         (clk),
        .rst         (rst),
        .crmd        (crmd),
        .dmw0        (dmw0),
        .dmw1        (dmw1),
        .reqValid    (dataReqValid),
        .reqVaddr    (dataVaddr),
        .reqOp       (dataOp),
        .reqTag      (dataTag),
        .stall       (dataStall),
        .flush       (dataFlush),
        .rspValid    (dataRspValid),
        .rspPaddr    (dataPaddr),
        .rspMemType  (dataMemType),
        .rspExcValid (dataExcValid),
        .rspExcCode  (dataExcCode),
        .rspExcSub   (dataExcSub),
        .rspTag      (dataRspTag)
    );

endmodule

//--- source/mmuCsrFile.sv
`timescale 1ns/10ps
`include "mmu_defs.svh"

module mmuCsrFile
    import mmuCsrPkg::*;
(
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         wbCyc,
    input  logic                         wbStb,
    input  logic                         wbWe,
    input  logic [`MMU_WB_ADR_WIDTH-1:0] wbAdr,
    input  logic [`MMU_WB_DAT_WIDTH-1:0] wbDatW,
    output logic [`MMU_WB_DAT_WIDTH-1:0] wbDatR,
    output logic                         wbAck,

    output crmd_t                        crmd,
    output dmw_t                         dmw0,
    output dmw_t                         dmw1
);

    crmd_t crmdReg;
    dmw_t  dmwReg [`MMU_DMW_COUNT];
    logic  wbReq;
    logic  wrEn;

    // ****************************************
    // wishbone handshake
    // ****************************************

    assign wbReq = wbCyc && wbStb && !wbAck; // new cycle seen.
    assign wrEn  = wbReq && wbWe;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wbAck <= 1'b0;
        end
        else
        begin
            wbAck <= wbReq; // single-cycle ack.
        end
    end

    // ****************************************
    // registers
    // ****************************************

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            crmdReg <= CRMD_RESET;
            for (int i = 0; i < `MMU_DMW_COUNT; i++)
            begin
                dmwReg[i] <= '0;
            end
        end
        else if (wrEn)
        begin
            case (wbAdr)
                `MMU_CSR_CRMD: crmdReg   <= wbDatW[CRMD_WIDTH-1:0] & CRMD_MASK;
                `MMU_CSR_DMW0: dmwReg[0] <= wbDatW & DMW_MASK;
                `MMU_CSR_DMW1: dmwReg[1] <= wbDatW & DMW_MASK;
                default:       ; // unmapped word.
            endcase
        end
    end

    // read data follows the address held by the master.
    always_comb
    begin
        case (wbAdr)
            `MMU_CSR_CRMD: wbDatR = {{(`MMU_WB_DAT_WIDTH-CRMD_WIDTH){1'b0}}, crmdReg};
            `MMU_CSR_DMW0: wbDatR = dmwReg[0];
            `MMU_CSR_DMW1: wbDatR = dmwReg[1];
            default:       wbDatR = '0;
        endcase
    end

    assign crmd = crmdReg;
    assign dmw0 = dmwReg[0];
    assign dmw1 = dmwReg[1];

    // ****************************************
    // checks
    // ****************************************

    // ack is a single pulse per request.
    ackSinglePulse: assert property (@(posedge clk) disable iff (rst)
        wbAck |=> !wbAck);

    // no ack without a request on the previous cycle.
    ackFollowsRequest: assert property (@(posedge clk) disable iff (rst)
        wbAck |-> $past(wbCyc && wbStb));

endmodule

//--- source/mmuCsrPkg.sv
`include "mmu_defs.svh"

package mmuCsrPkg;

    typedef logic [1:0] plv_t;     // privilege level.
    typedef logic [1:0] memType_t; // memory access type.

    localparam plv_t PLV_KERNEL = 2'd0;
    localparam plv_t PLV_USER   = 2'd3;

    // {PG, DA} pair; direct translation is DA=1, PG=0.
    typedef logic [1:0] xlatMode_t;
    localparam xlatMode_t MODE_DIRECT = 2'b01;

    // ****************************************
    // CRMD
    // ****************************************

    localparam int CRMD_WIDTH = 9;
    typedef logic [CRMD_WIDTH-1:0] crmd_t;

    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5; // fetch memory type.
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATM_LO = 7; // load/store memory type.
    localparam int CRMD_DATM_HI = 8;

    localparam crmd_t CRMD_MASK  = 9'h1fb; // bit 2 not implemented.
    localparam crmd_t CRMD_RESET = 9'h008; // direct mode, plv 0.

    // ****************************************
    // DMW
    // ****************************************

    typedef logic [`MMU_WB_DAT_WIDTH-1:0] dmw_t;

    localparam int DMW_PLV0    = 0;
    localparam int DMW_PLV3    = 3;
    localparam int DMW_MAT_LO  = 4;
    localparam int DMW_MAT_HI  = 5;
    localparam int DMW_PSEG_LO = 25;
    localparam int DMW_PSEG_HI = 27;
    localparam int DMW_VSEG_LO = 29;
    localparam int DMW_VSEG_HI = 31;

    localparam dmw_t DMW_MASK = 32'hee00_0039; // only the fields above.

endpackage

//--- source/mmuXlatPkg.sv
package mmuXlatPkg;

    // ****************************************
    // request kind
    // ****************************************

    typedef enum logic [1:0]
    {
        FETCH = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } opKind_t;

    // ****************************************
    // exception reporting
    // ****************************************

    typedef logic [5:0] excCode_t;
    typedef logic [8:0] excSub_t;

    localparam excCode_t NO_EXC = 6'h00; // code field when nothing raised.
    localparam excCode_t ADE    = 6'h08; // address error.
    localparam excCode_t TLBR   = 6'h3f; // tlb refill.

    localparam excSub_t ADEF = 9'h000; // on fetch.
    localparam excSub_t ADEM = 9'h001; // on load or store.
    localparam excSub_t NONE = 9'h000;

    // ****************************************
    // per-port tags
    // ****************************************

    // word address of the fetched instruction.
    typedef logic [29:0] fetchTag_t;

    // load/store queue index.
    typedef logic [7:0] dataTag_t;

endpackage

//--- source/mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// ****************************************
// address and data widths
// ****************************************

`define MMU_VA_WIDTH      32 // virtual address.
`define MMU_PA_WIDTH      32 // physical address.
`define MMU_WB_ADR_WIDTH  2  // csr word address.
`define MMU_WB_DAT_WIDTH  32

// ****************************************
// csr map
// ****************************************

`define MMU_CSR_CRMD  2'd0
`define MMU_CSR_DMW0  2'd1
`define MMU_CSR_DMW1  2'd2
// word 3 is unmapped and reads as zero

// number of direct-mapped windows.
`define MMU_DMW_COUNT 2

`endif

//--- tb.f
+incdir+source
+incdir+tb
source/mmuCsrPkg.sv
source/mmuXlatPkg.sv
source/mmuCsrFile.sv
source/addressTranslator.sv
source/memoryMappingUnit.sv
tb/tbMemoryMappingUnit.sv

//--- tb/mmuModel.svh
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

// expected port response with the tag widened to 30 bits.
typedef struct packed
{
    logic [31:0] paddr;
    logic [1:0]  memType;
    logic        excValid;
    logic [5:0]  excCode;
    logic [8:0]  excSub;
    logic [29:0] tag;
} expRsp_t;

// csr mirror of every acknowledged write.
logic [8:0]  crmdM     = 9'h008;
logic [31:0] dmw0M     = '0;
logic [31:0] dmw1M     = '0;
logic [31:0] lfsrState = 32'h6f40_dce4;

// fibonacci lfsr with taps 32 22 2 1.
function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
        fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        v         = {v[30:0], fb};
    end
    return v;
endfunction

function automatic logic inWindow(input logic [31:0] dmw, input logic [31:0] va);
    if (dmw[31:29] != va[31:29])
    begin
        return 1'b0;
    end
    return (crmdM[1:0] == 2'd0) ? dmw[0] : ((crmdM[1:0] == 2'd3) ? dmw[3] : 1'b0);
endfunction

function automatic expRsp_t expectXlat(input logic [31:0] va, input opKind_t op,
                                       input logic [29:0] tag);
    expRsp_t r;
    logic    isFetch;
    r       = '0;
    r.tag   = tag;
    isFetch = (op == FETCH);
    if (crmdM[3] && !crmdM[4]) // direct mode.
    begin
        r.paddr   = va;
        r.memType = isFetch ? crmdM[6:5] : crmdM[8:7];
    end
    else if (inWindow(dmw0M, va))
    begin
        r.paddr   = {dmw0M[27:25], va[28:0]};
        r.memType = dmw0M[5:4];
    end
    else if (inWindow(dmw1M, va))
    begin
        r.paddr   = {dmw1M[27:25], va[28:0]};
        r.memType = dmw1M[5:4];
    end
    else
    begin
        r.excValid = 1'b1;
        r.excCode  = (crmdM[1:0] != 2'd0 && va[31]) ? 6'h08 : 6'h3f;
        r.excSub   = (r.excCode == 6'h08 && !isFetch) ? 9'd1 : 9'd0;
    end
    return r;
endfunction

function automatic void mirrorWrite(input logic [1:0] adr, input logic [31:0] data);
    case (adr)
        2'd0:    crmdM = data[8:0] & 9'h1fb; // bit 2 unused.
        2'd1:    dmw0M = data & 32'hee00_0039;
        2'd2:    dmw1M = data & 32'hee00_0039;
        default: ;
    endcase
endfunction

function automatic logic [31:0] mirrorRead(input logic [1:0] adr);
    case (adr)
        2'd0:    return {23'd0, crmdM};
        2'd1:    return dmw0M;
        2'd2:    return dmw1M;
        default: return '0;
    endcase
endfunction

`endif

//--- tb/tbMemoryMappingUnit.sv
`timescale 1ns/10ps
`include "mmu_defs.svh"

module tbMemoryMappingUnit
    import mmuCsrPkg::*;
    import mmuXlatPkg::*;
;

    localparam int TRAFFIC_CYCLES = 300;
    localparam int CONFIGS        = 8;
    localparam int TIMEOUT_CYCLES = 6000; // twice 8 configs x 300 cycles plus csr work.

    // csr values per configuration with random values in the last one.
    localparam logic [31:0] CFG_CRMD [CONFIGS] = '{32'h008, 32'h12b, 32'h010, 32'h010,
                                                   32'h013, 32'h011, 32'h012, 32'h000};
    localparam logic [31:0] CFG_DMW0 [CONFIGS] = '{32'h0, 32'h2600_0039, 32'h8000_0011,
        32'h2600_0039, 32'hc200_0021, 32'h2600_0039, 32'h2600_0039, 32'h0};
    localparam logic [31:0] CFG_DMW1 [CONFIGS] = '{32'h0, 32'hea00_0039, 32'h8e00_0021,
        32'ha400_0011, 32'hea00_0038, 32'hea00_0039, 32'hea00_0039, 32'h0};

    logic                         clk;
    logic                         rst;
    logic                         wbCyc;
    logic                         wbStb;
    logic                         wbWe;
    logic [`MMU_WB_ADR_WIDTH-1:0] wbAdr;
    logic [`MMU_WB_DAT_WIDTH-1:0] wbDatW;
    logic [`MMU_WB_DAT_WIDTH-1:0] wbDatR;
    logic                         wbAck;
    logic                         fetchReqValid;
    logic                         fetchStall;
    logic                         fetchFlush;
    logic [`MMU_VA_WIDTH-1:0]     fetchVaddr;
    fetchTag_t                    fetchTag;
    fetchTag_t                    fetchRspTag;
    logic                         fetchRspValid;
    logic                         fetchExcValid;
    logic [`MMU_PA_WIDTH-1:0]     fetchPaddr;
    memType_t                     fetchMemType;
    excCode_t                     fetchExcCode;
    excSub_t                      fetchExcSub;
    logic                         dataReqValid;
    logic                         dataStall;
    logic                         dataFlush;
    logic [`MMU_VA_WIDTH-1:0]     dataVaddr;
    opKind_t                      dataOp;
    dataTag_t                     dataTag;
    dataTag_t                     dataRspTag;
    logic                         dataRspValid;
    logic                         dataExcValid;
    logic [`MMU_PA_WIDTH-1:0]     dataPaddr;
    memType_t                     dataMemType;
    excCode_t                     dataExcCode;
    excSub_t                      dataExcSub;

    `include "mmuModel.svh"

    expRsp_t fetchAct;
    expRsp_t dataAct;
    expRsp_t expQ [2][$]; // 0 fetch, 1 data.
    int      checkedCount = 0;
    int      cycleCount   = 0;

    memoryMappingUnit DUT (.*);

    assign fetchAct = {fetchPaddr, fetchMemType, fetchExcValid, fetchExcCode, fetchExcSub,
                       fetchRspTag};
    assign dataAct  = {dataPaddr, dataMemType, dataExcValid, dataExcCode, dataExcSub,
                       22'd0, dataRspTag};

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES)
        begin
            reportFailure("simulation ran past its cycle limit");
        end
    end

    // ****************************************
    // checking
    // ****************************************

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal)
        else reportFailure($sformatf("CHECK FAILED %s expected %h actual %h",
                                     name, expVal, actVal));
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond === 1'b1)
        else reportFailure(what);
    endtask

    task automatic compareResponse(input string port, input expRsp_t e, input expRsp_t a);
        checkValue({port, " paddr"}, e.paddr, a.paddr);
        checkValue({port, " memType"}, 32'(e.memType), 32'(a.memType));
        checkValue({port, " excValid"}, 32'(e.excValid), 32'(a.excValid));
        if (e.excValid)
        begin
            checkValue({port, " excCode"}, 32'(e.excCode), 32'(a.excCode));
            checkValue({port, " excSub"}, 32'(e.excSub), 32'(a.excSub));
        end
        checkValue({port, " tag"}, 32'(e.tag), 32'(a.tag));
        checkedCount++;
    endtask

    // checks the held response and models the coming edge.
    task automatic stepPort(input int p, input logic rspIn, input expRsp_t act,
                            input logic reqIn, input logic stallIn, input logic flushIn,
                            input expRsp_t nextExp);
        string port;
        port = (p == 0) ? "fetch" : "data";
        checkTrue(rspIn || expQ[p].size() == 0, {port, " port lost an accepted request"});
        checkTrue(!rspIn || expQ[p].size() != 0, {port, " port responded without a request"});
        if (rspIn)
        begin
            compareResponse(port, expQ[p][0], act);
        end
        if (flushIn || !stallIn)
        begin
            expQ[p].delete(); // flush drops and an unstalled edge consumes.
        end
        if (reqIn && !stallIn && !flushIn)
        begin
            expQ[p].push_back(nextExp);
        end
    endtask

    always @(negedge clk)
    begin
        if (!rst)
        begin
            stepPort(0, fetchRspValid, fetchAct, fetchReqValid, fetchStall, fetchFlush,
                     expectXlat(fetchVaddr, FETCH, fetchTag));
            stepPort(1, dataRspValid, dataAct, dataReqValid, dataStall, dataFlush,
                     expectXlat(dataVaddr, dataOp, {22'd0, dataTag}));
        end
    end

    // ****************************************
    // stimulus
    // ****************************************

    task automatic wbAccess(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = wdat;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!wbAck);
        rdat  = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic writeCsr(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wbAccess(1'b1, adr, data, unused);
        mirrorWrite(adr, data);
    endtask

    task automatic readCsr(input logic [1:0] adr);
        logic [31:0] got;
        wbAccess(1'b0, adr, '0, got);
        checkValue($sformatf("csr read %0d", adr), mirrorRead(adr), got);
    endtask

    task automatic idlePorts();
        fetchReqValid = 1'b0;
        fetchVaddr    = '0;
        fetchTag      = '0;
        fetchStall    = 1'b0;
        fetchFlush    = 1'b0;
        dataReqValid  = 1'b0;
        dataVaddr     = '0;
        dataOp        = LOAD;
        dataTag       = '0;
        dataStall     = 1'b0;
        dataFlush     = 1'b0;
    endtask

    // random address often steered into a window segment.
    function automatic logic [31:0] pickAddress();
        logic [31:0] va;
        logic [1:0]  sel;
        va  = randBits(32);
        sel = 2'(randBits(2));
        if (sel == 2'd0)
        begin
            va[31:29] = dmw0M[31:29];
        end
        else if (sel == 2'd1)
        begin
            va[31:29] = dmw1M[31:29];
        end
        return va;
    endfunction

    task automatic runTraffic(input int cycles);
        int c;
        for (c = 0; c < cycles; c++)
        begin
            fetchReqValid = (randBits(2) != 0);
            fetchVaddr    = pickAddress();
            fetchTag      = fetchTag_t'(randBits(30));
            fetchStall    = (randBits(3) == 0);
            fetchFlush    = (randBits(4) == 0);
            dataReqValid  = (randBits(2) != 0);
            dataVaddr     = pickAddress();
            dataOp        = randBits(1) ? STORE : LOAD;
            dataTag       = dataTag_t'(randBits(8));
            dataStall     = (randBits(3) == 0);
            dataFlush     = (randBits(4) == 0);
            @(posedge clk);
            #1;
        end
        idlePorts();
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic applyConfig(input int cfg);
        logic [31:0] crmdVal;
        logic [31:0] dmw0Val;
        logic [31:0] dmw1Val;
        int          adr;
        crmdVal = CFG_CRMD[cfg];
        dmw0Val = CFG_DMW0[cfg];
        dmw1Val = CFG_DMW1[cfg];
        if (cfg == CONFIGS - 1)
        begin
            crmdVal = randBits(32);
            dmw0Val = randBits(32);
            dmw1Val = randBits(32);
        end
        writeCsr(`MMU_CSR_CRMD, crmdVal);
        writeCsr(`MMU_CSR_DMW0, dmw0Val);
        writeCsr(`MMU_CSR_DMW1, dmw1Val);
        writeCsr(2'd3, randBits(32)); // unmapped word.
        for (adr = 0; adr < 4; adr++)
        begin
            readCsr(2'(adr));
        end
    endtask

    initial
    begin
        int cfg;
        int adr;
        rst    = 1'b1;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        idlePorts();
        fetchReqValid = 1'b1; // requests under reset must be dropped.
        dataReqValid  = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        idlePorts();
        repeat (3) @(posedge clk); // ports must stay quiet.
        #1;
        for (adr = 0; adr < 4; adr++)
        begin
            readCsr(2'(adr));
        end
        for (cfg = 0; cfg < CONFIGS; cfg++)
        begin
            applyConfig(cfg);
            runTraffic(TRAFFIC_CYCLES);
        end
        if (expQ[0].size() == 0 && expQ[1].size() == 0 && checkedCount > 1000)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            reportFailure("responses left pending or too few responses checked");
        end
    end

endmodule
